//--- build.f
mgr_pkg.sv
wu_fetch.sv
wu_memory.sv
wu_decode.sv
stu_cntl.sv
manager.sv
tb_manager.sv

//--- Bender.yml
package:
  name: manager

sources:
  - mgr_pkg.sv
  - wu_fetch.sv
  - wu_memory.sv
  - wu_decode.sv
  - stu_cntl.sv
  - manager.sv
  - target: test
    files:
      - tb_manager.sv

//--- tb_manager.sv
// Testbench for the manager top level with random runs and upstream beats checked against a queue model
`timescale 1ns/1ps

module tb_manager;

  localparam int NUM_RUNS       = 4;
  localparam int NUM_BEATS      = 40;
  localparam int TIMEOUT_CYCLES = 20 * (mgr_pkg::WU_DEPTH + NUM_BEATS) + 500;

  logic                clk;
  logic                rst_n;
  logic                run_valid;
  mgr_pkg::wu_run_t    run;
  logic                run_ready;
  logic                load_valid;
  mgr_pkg::wu_load_t   load;
  logic                oob_valid;
  mgr_pkg::oob_desc_t  oob;
  logic                oob_ready;
  logic                stu_valid;
  mgr_pkg::stu_beat_t  stu;
  logic                stu_ready;
  logic                rdp_valid;
  mgr_pkg::ret_beat_t  rdp;
  logic                rdp_ready;
  logic                rcp_valid;
  mgr_pkg::ret_beat_t  rcp;
  logic                rcp_ready;

  // Model state
  integer              seed = 35;
  int                  cycle_cnt = 0;
  logic                drain_all = 1'b0;
  logic [31:0]         ready_r;
  mgr_pkg::wu_entry_t  mem_model [mgr_pkg::WU_DEPTH];
  mgr_pkg::tag_t       exp_tag = '0;
  mgr_pkg::oob_desc_t  exp_oob [$];
  mgr_pkg::ret_beat_t  exp_rdp [$];
  mgr_pkg::ret_beat_t  exp_rcp [$];
  mgr_pkg::oob_desc_t  exp_d;
  mgr_pkg::ret_beat_t  exp_b;
  logic                oob_hold = 1'b0;
  mgr_pkg::oob_desc_t  oob_last;

  manager uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .run_valid  (run_valid),
    .run        (run),
    .run_ready  (run_ready),
    .load_valid (load_valid),
    .load       (load),
    .oob_valid  (oob_valid),
    .oob        (oob),
    .oob_ready  (oob_ready),
    .stu_valid  (stu_valid),
    .stu        (stu),
    .stu_ready  (stu_ready),
    .rdp_valid  (rdp_valid),
    .rdp        (rdp),
    .rdp_ready  (rdp_ready),
    .rcp_valid  (rcp_valid),
    .rcp        (rcp),
    .rcp_ready  (rcp_ready)
  );

  // ------------------------------------------------------------
  // Error reporting
  // ------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s at %0t", msg, $time);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  // Later slot wins so slot 1 is looked at first
  function automatic mgr_pkg::opt_value_t pick_value(input mgr_pkg::wu_entry_t e,
                                                     input mgr_pkg::opt_type_e kind);
    if (e.opt[1].opt_type == kind) begin
      return e.opt[1].value;
    end
    if (e.opt[0].opt_type == kind) begin
      return e.opt[0].value;
    end
    return '0;
  endfunction

  // Expected descriptors for a whole run queued before the run starts
  task automatic queue_run(input mgr_pkg::wu_run_t cmd);
    mgr_pkg::wu_addr_t   addr;
    mgr_pkg::wu_entry_t  e;
    mgr_pkg::oob_desc_t  d;
    addr = cmd.start_addr;
    for (int i = 0; i < cmd.count; i++) begin
      e = mem_model[addr];
      if (e.op == mgr_pkg::OP) begin
        d.tag       = exp_tag;
        d.num_lanes = pick_value(e, mgr_pkg::NUM_LANES);
        d.stop_cmd  = pick_value(e, mgr_pkg::STOP_CMD);
        d.simd_cmd  = pick_value(e, mgr_pkg::SIMD_CMD);
        exp_oob.push_back(d);
        exp_tag++;
      end
      // 6-bit address wraps at the end of memory
      addr++;
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------
  task automatic load_memory();
    logic [31:0] r;
    for (int a = 0; a < mgr_pkg::WU_DEPTH; a++) begin
      r = $random(seed);
      @(negedge clk);
      load_valid = 1'b1;
      load.addr  = mgr_pkg::wu_addr_t'(a);
      load.entry = r[21:0];
      mem_model[a] = r[21:0];
    end
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  task automatic do_run();
    logic [31:0]       r;
    mgr_pkg::wu_run_t  cmd;
    r = $random(seed);
    cmd.start_addr = r[5:0];
    cmd.count      = {1'b0, r[13:8]} + 7'd1;
    queue_run(cmd);
    @(negedge clk);
    run_valid = 1'b1;
    run       = cmd;
    do @(posedge clk); while (!run_ready);
    @(negedge clk);
    run_valid = 1'b0;
    // Fetch back in IDLE before the next run
    do @(negedge clk); while (!run_ready);
  endtask

  task automatic send_beats(input int n);
    logic [31:0]         r;
    mgr_pkg::stu_beat_t  b;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      b.cntl      = mgr_pkg::intf_cntl_e'(r[1:0]);
      b.beat_type = mgr_pkg::stu_type_e'(r[2]);
      b.tag       = r[6:3];
      b.data      = $random(seed);
      @(negedge clk);
      // Occasional idle cycle between beats
      if (r[8:7] == 2'b00) begin
        stu_valid = 1'b0;
        @(negedge clk);
      end
      stu_valid = 1'b1;
      stu       = b;
      do @(posedge clk); while (!stu_ready);
    end
    @(negedge clk);
    stu_valid = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Clock, readies, timeout
  // ------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Random back-pressure released during the final drain
  always @(negedge clk) begin
    ready_r   = $random(seed);
    oob_ready = drain_all || (ready_r[1:0] != 2'b00);
    rdp_ready = drain_all || (ready_r[3:2] != 2'b00);
    rcp_ready = drain_all || (ready_r[5:4] != 2'b00);
  end

  always @(posedge clk) begin
    cycle_cnt++;
    assert (cycle_cnt < TIMEOUT_CYCLES) else report_error("run did not finish in time");
  end

  // ------------------------------------------------------------
  // Output monitor sampled on the rising edge
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      if (oob_hold) begin
        assert (oob_valid) else report_error("oob_valid dropped under back-pressure");
        assert (oob === oob_last) else report_mismatch("oob", oob, oob_last);
      end
      oob_hold = oob_valid && !oob_ready;
      oob_last = oob;
      if (oob_valid && oob_ready) begin
        assert (exp_oob.size() > 0) else report_error("descriptor arrived with none expected");
        exp_d = exp_oob.pop_front();
        assert (oob === exp_d) else report_mismatch("oob", oob, exp_d);
      end
      // Upstream beats routed by type
      if (stu_valid && stu_ready) begin
        exp_b = '{cntl: stu.cntl, tag: stu.tag, data: stu.data};
        if (stu.beat_type == mgr_pkg::CTRL) begin
          exp_rcp.push_back(exp_b);
        end else begin
          exp_rdp.push_back(exp_b);
        end
      end
      if (rdp_valid && rdp_ready) begin
        assert (exp_rdp.size() > 0) else report_error("data beat arrived with none expected");
        exp_b = exp_rdp.pop_front();
        assert (rdp === exp_b) else report_mismatch("rdp", rdp, exp_b);
      end
      if (rcp_valid && rcp_ready) begin
        assert (exp_rcp.size() > 0) else report_error("control beat arrived with none expected");
        exp_b = exp_rcp.pop_front();
        assert (rcp === exp_b) else report_mismatch("rcp", rcp, exp_b);
      end
    end
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    rst_n      = 1'b0;
    run_valid  = 1'b0;
    run        = '0;
    load_valid = 1'b0;
    load       = '0;
    oob_ready  = 1'b0;
    stu_valid  = 1'b0;
    stu        = '0;
    rdp_ready  = 1'b0;
    rcp_ready  = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    assert (!oob_valid) else report_mismatch("oob_valid", oob_valid, 0);
    assert (!rdp_valid) else report_mismatch("rdp_valid", rdp_valid, 0);
    assert (!rcp_valid) else report_mismatch("rcp_valid", rcp_valid, 0);
    assert (run_ready) else report_mismatch("run_ready", run_ready, 1);
    rst_n = 1'b1;

    // Work-unit path and upstream path in parallel
    fork
      begin
        load_memory();
        for (int i = 0; i < NUM_RUNS; i++) begin
          do_run();
        end
      end
      send_beats(NUM_BEATS);
    join

    while (exp_oob.size() != 0 || exp_rdp.size() != 0 || exp_rcp.size() != 0) begin
      @(negedge clk);
    end
    drain_all = 1'b1;
    repeat (5) @(negedge clk);
    assert (!oob_valid && !rdp_valid && !rcp_valid)
      else report_error("extra output left valid after all expected transfers");
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- manager.sv
// Manager top level, joins work-unit fetch, memory and decode with the upstream controller
`timescale 1ns/1ps

module manager (
  input  logic                clk,
  input  logic                rst_n,

  // Run command
  input  logic                run_valid,
  input  mgr_pkg::wu_run_t    run,
  output logic                run_ready,

  // Work-unit memory load
  input  logic                load_valid,
  input  mgr_pkg::wu_load_t   load,

  // Stack-bus downstream OOB
  output logic                oob_valid,
  output mgr_pkg::oob_desc_t  oob,
  input  logic                oob_ready,

  // Stack-bus upstream
  input  logic                stu_valid,
  input  mgr_pkg::stu_beat_t  stu,
  output logic                stu_ready,

  // Return data and return control
  output logic                rdp_valid,
  output mgr_pkg::ret_beat_t  rdp,
  input  logic                rdp_ready,
  output logic                rcp_valid,
  output mgr_pkg::ret_beat_t  rcp,
  input  logic                rcp_ready
);

  // ------------------------------------------------------------
  // Fetch to memory
  // ------------------------------------------------------------
  logic               rd_en;
  mgr_pkg::wu_addr_t  rd_addr;
  logic               stall;

  wu_fetch u_wu_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .run_valid (run_valid),
    .run       (run),
    .run_ready (run_ready),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .stall     (stall)
  );

  // ------------------------------------------------------------
  // Memory to decode
  // ------------------------------------------------------------
  logic                ent_valid;
  mgr_pkg::wu_entry_t  ent;
  logic                ent_ready;

  wu_memory u_wu_memory (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_valid (load_valid),
    .load       (load),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .stall      (stall),
    .ent_valid  (ent_valid),
    .ent        (ent),
    .ent_ready  (ent_ready)
  );

  wu_decode u_wu_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .ent_valid (ent_valid),
    .ent       (ent),
    .ent_ready (ent_ready),
    .oob_valid (oob_valid),
    .oob       (oob),
    .oob_ready (oob_ready)
  );

  // Upstream path is independent of the work-unit path
  stu_cntl u_stu_cntl (
    .clk       (clk),
    .rst_n     (rst_n),
    .stu_valid (stu_valid),
    .stu       (stu),
    .stu_ready (stu_ready),
    .rdp_valid (rdp_valid),
    .rdp       (rdp),
    .rdp_ready (rdp_ready),
    .rcp_valid (rcp_valid),
    .rcp       (rcp),
    .rcp_ready (rcp_ready)
  );

endmodule

//--- stu_cntl.sv
// Stack-bus upstream controller, registers each beat and routes it to return data or return control
`timescale 1ns/1ps

module stu_cntl (
  input  logic                clk,
  input  logic                rst_n,

  // Upstream stack bus
  input  logic                stu_valid,
  input  mgr_pkg::stu_beat_t  stu,
  output logic                stu_ready,

  // Return data path
  output logic                rdp_valid,
  output mgr_pkg::ret_beat_t  rdp,
  input  logic                rdp_ready,

  // Return control path
  output logic                rcp_valid,
  output mgr_pkg::ret_beat_t  rcp,
  input  logic                rcp_ready
);

  // Index 0 is data, index 1 is control
  logic [1:0]          sel;
  logic [1:0]          out_ready;
  logic [1:0]          out_free;
  logic [1:0]          out_valid;
  logic [1:0]          take;
  mgr_pkg::ret_beat_t  out_q [2];
  mgr_pkg::ret_beat_t  beat;

  assign sel       = (stu.beat_type == mgr_pkg::CTRL) ? 2'b10 : 2'b01;
  assign out_ready = {rcp_ready, rdp_ready};

  // Ready depends only on the register this beat targets
  assign stu_ready = |(sel & out_free);
  assign take      = sel & {2{stu_valid && stu_ready}};

  // Type bit is dropped on the way out
  assign beat = '{cntl: stu.cntl, tag: stu.tag, data: stu.data};

  // ------------------------------------------------------------
  // Per-output register
  // ------------------------------------------------------------
  for (genvar g = 0; g < 2; g++) begin : g_out
    assign out_free[g] = !out_valid[g] || out_ready[g];

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        out_valid[g] <= 1'b0;
      end else if (take[g]) begin
        out_valid[g] <= 1'b1;
      end else if (out_ready[g]) begin
        out_valid[g] <= 1'b0;
      end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
      if (take[g]) begin
        out_q[g] <= beat;
      end
    end

    // Routed beat held under back-pressure
    a_out_hold : assert property (
      @(posedge clk) disable iff (!rst_n)
      (out_valid[g] && !out_ready[g]) |=> (out_valid[g] && $stable(out_q[g]))
    );
  end

  assign rdp_valid = out_valid[0];
  assign rdp       = out_q[0];
  assign rcp_valid = out_valid[1];
  assign rcp       = out_q[1];

endmodule

//--- wu_decode.sv
// Work-unit decode that turns OP entries into tagged OOB configuration descriptors and drops the rest
`timescale 1ns/1ps

module wu_decode (
  input  logic                clk,
  input  logic                rst_n,

  // Entry stream from memory
  input  logic                ent_valid,
  input  mgr_pkg::wu_entry_t  ent,
  output logic                ent_ready,

  // Stack-bus downstream OOB
  output logic                oob_valid,
  output mgr_pkg::oob_desc_t  oob,
  input  logic                oob_ready
);

  mgr_pkg::tag_t       tag_cnt;
  mgr_pkg::oob_desc_t  desc;
  logic                is_op;
  logic                ent_take;
  logic                emit;

  // Free when empty or draining this cycle
  assign ent_ready = !oob_valid || oob_ready;
  assign ent_take  = ent_valid && ent_ready;

  // MR and MW fall through as NOP
  assign is_op = (ent.op == mgr_pkg::OP);
  assign emit  = ent_take && is_op;

  // ------------------------------------------------------------
  // Descriptor build
  // ------------------------------------------------------------
  always_comb begin
    desc     = '0;
    desc.tag = tag_cnt;
    // Ascending slot order so slot 1 wins on a clash
    for (int i = 0; i < mgr_pkg::OPT_PER_INST; i++) begin
      case (ent.opt[i].opt_type)
        mgr_pkg::NUM_LANES: desc.num_lanes = ent.opt[i].value;
        mgr_pkg::STOP_CMD:  desc.stop_cmd  = ent.opt[i].value;
        mgr_pkg::SIMD_CMD:  desc.simd_cmd  = ent.opt[i].value;
        default: begin
          // NONE leaves the field at zero
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Output stage
  // ------------------------------------------------------------

  // Valid flag and tag sequence
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      oob_valid <= 1'b0;
      tag_cnt   <= '0;
    end else begin
      if (emit) begin
        oob_valid <= 1'b1;
      end else if (oob_ready) begin
        oob_valid <= 1'b0;
      end
      // One tag per emitted descriptor and wrapping across runs
      if (emit) begin
        tag_cnt <= tag_cnt + 1'b1;
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (emit) begin
      oob <= desc;
    end
  end

  // Descriptor held while downstream stalls
  a_oob_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    (oob_valid && !oob_ready) |=> (oob_valid && $stable(oob))
  );

endmodule

//--- wu_memory.sv
// Work-unit storage, loaded through a write port and read by fetch into a held output register
`timescale 1ns/1ps

module wu_memory (
  input  logic                clk,
  input  logic                rst_n,

  // Load port, always accepted
  input  logic                load_valid,
  input  mgr_pkg::wu_load_t   load,

  // Read request from fetch
  input  logic                rd_en,
  input  mgr_pkg::wu_addr_t   rd_addr,
  output logic                stall,

  // Entry stream to decode
  output logic                ent_valid,
  output mgr_pkg::wu_entry_t  ent,
  input  logic                ent_ready
);

  mgr_pkg::wu_entry_t  mem [mgr_pkg::WU_DEPTH];
  logic                rd_take;

  // Held entry blocks the next read
  assign stall   = ent_valid && !ent_ready;
  assign rd_take = rd_en && !stall;

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (load_valid) begin
      mem[load.addr] <= load.entry;
    end
  end

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------

  // Valid flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ent_valid <= 1'b0;
    end else if (rd_take) begin
      ent_valid <= 1'b1;
    end else if (ent_ready) begin
      ent_valid <= 1'b0;
    end
  end

  // Payload, refreshed only on a taken read
  always_ff @(posedge clk) begin
    if (rd_take) begin
      ent <= mem[rd_addr];
    end
  end

  // Entry held steady until decode takes it
  a_ent_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    (ent_valid && !ent_ready) |=> (ent_valid && $stable(ent))
  );

endmodule

//--- wu_fetch.sv
// Work-unit fetch, takes a run command and walks the memory address range one read at a time
`timescale 1ns/1ps

module wu_fetch (
  input  logic               clk,
  input  logic               rst_n,

  // Run command
  input  logic               run_valid,
  input  mgr_pkg::wu_run_t   run,
  output logic               run_ready,

  // Read port to work-unit memory
  output logic               rd_en,
  output mgr_pkg::wu_addr_t  rd_addr,
  input  logic               stall
);

  mgr_pkg::fetch_state_e        state;
  mgr_pkg::wu_addr_t            cur_addr;
  logic [mgr_pkg::WU_ADDR_W:0]  remaining;
  logic                         last_read;

  // Only idle fetch takes a new run
  assign run_ready = (state == mgr_pkg::IDLE);
  assign rd_en     = (state == mgr_pkg::RUN);
  assign rd_addr   = cur_addr;
  assign last_read = (remaining == {{mgr_pkg::WU_ADDR_W{1'b0}}, 1'b1});

  // ------------------------------------------------------------
  // Sequencer
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= mgr_pkg::IDLE;
      cur_addr  <= '0;
      remaining <= '0;
    end else begin
      case (state)
        mgr_pkg::IDLE: begin
          if (run_valid) begin
            cur_addr  <= run.start_addr;
            remaining <= run.count;
            // Zero count would never terminate
            if (run.count != '0) begin
              state <= mgr_pkg::RUN;
            end
          end
        end
        default: begin
          // Advance only on an accepted read, address wraps at top of memory
          if (!stall) begin
            cur_addr  <= cur_addr + 1'b1;
            remaining <= remaining - 1'b1;
            if (last_read) begin
              state <= mgr_pkg::IDLE;
            end
          end
        end
      endcase
    end
  end

  // No further reads once the last one of a run is taken
  a_stop_after_last : assert property (
    @(posedge clk) disable iff (!rst_n)
    (rd_en && !stall && last_read) |=> (run_ready && !rd_en)
  );

endmodule

//--- mgr_pkg.sv
// Shared widths, encodings and bus structs for the manager work-unit and upstream paths
package mgr_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------

  // Work-unit memory addressing
  localparam int WU_ADDR_W    = 6;
  localparam int WU_DEPTH     = 64;

  // Option slots carried by every work-unit entry
  localparam int OPT_PER_INST = 2;

  // OOB descriptor tag, also echoed back on the upstream bus
  localparam int TAG_W        = 4;
  localparam int STU_DATA_W   = 32;

  // ------------------------------------------------------------
  // Plain vector types
  // ------------------------------------------------------------

  typedef logic [WU_ADDR_W-1:0]  wu_addr_t;
  typedef logic [7:0]            opt_value_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [STU_DATA_W-1:0] stu_data_t;

  // ------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------

  // Entry kind, only OP produces a descriptor
  typedef enum logic [1:0] {
    NOP = 2'd0,
    OP  = 2'd1,
    MR  = 2'd2,
    MW  = 2'd3
  } inst_op_e;

  // Which descriptor field an option slot writes
  typedef enum logic [1:0] {
    NONE      = 2'd0,
    NUM_LANES = 2'd1,
    STOP_CMD  = 2'd2,
    SIMD_CMD  = 2'd3
  } opt_type_e;

  // Packet delineator on stack-bus beats
  typedef enum logic [1:0] {
    SOP    = 2'd0,
    MOP    = 2'd1,
    EOP    = 2'd2,
    SINGLE = 2'd3
  } intf_cntl_e;

  // Upstream beat kind, selects return output
  typedef enum logic {
    DATA = 1'b0,
    CTRL = 1'b1
  } stu_type_e;

  typedef enum logic {
    IDLE = 1'b0,
    RUN  = 1'b1
  } fetch_state_e;

  // ------------------------------------------------------------
  // Bus payloads
  // ------------------------------------------------------------

  typedef struct packed {
    opt_type_e  opt_type;
    opt_value_t value;
  } wu_opt_t;

  // Slot 0 sits in the low bits
  typedef struct packed {
    inst_op_e                   op;
    wu_opt_t [OPT_PER_INST-1:0] opt;
  } wu_entry_t;

  // Count is 1 to WU_DEPTH, hence one extra bit
  typedef struct packed {
    wu_addr_t             start_addr;
    logic [WU_ADDR_W:0]   count;
  } wu_run_t;

  typedef struct packed {
    wu_addr_t  addr;
    wu_entry_t entry;
  } wu_load_t;

  typedef struct packed {
    tag_t       tag;
    opt_value_t num_lanes;
    opt_value_t stop_cmd;
    opt_value_t simd_cmd;
  } oob_desc_t;

  typedef struct packed {
    intf_cntl_e cntl;
    stu_type_e  beat_type;
    tag_t       tag;
    stu_data_t  data;
  } stu_beat_t;

  typedef struct packed {
    intf_cntl_e cntl;
    tag_t       tag;
    stu_data_t  data;
  } ret_beat_t;

endpackage
